// ==== logic/core_cfg.svh ====
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_COLUMNS      4     // neurons
`define CORE_ROWS         8     // weights per neuron, input vector length
`define CORE_WEIGHT_BITS  8

// two delta bits per column, also carries a set value or an input vector
`define CORE_DATA_BITS    (2*`CORE_COLUMNS)

`endif

// ==== logic/neuron_pkg.sv ====
`include "core_cfg.svh"

package neuron_pkg;
    localparam int COL_BITS = $clog2(`CORE_COLUMNS);
    localparam int ROW_BITS = $clog2(`CORE_ROWS);

    typedef logic signed [`CORE_WEIGHT_BITS-1:0] weight_t;
    typedef logic [COL_BITS-1:0] col_t;
    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic signed [`CORE_WEIGHT_BITS+ROW_BITS-1:0] score_t;   // room for ROWS weights

    typedef struct packed {
        logic is_increment;
        col_t col;
        row_t row;
    } wm_inst_t;
endpackage

// ==== logic/cmd_pkg.sv ====
`include "core_cfg.svh"

package cmd_pkg;
    typedef enum logic [1:0] {
        SET  = 2'd0,
        INC  = 2'd1,
        READ = 2'd2,
        EVAL = 2'd3
    } opcode_e;

    // host command, data meaning depends on op
    typedef struct packed {
        opcode_e                    op;
        neuron_pkg::col_t           col;
        neuron_pkg::row_t           row;
        logic [`CORE_DATA_BITS-1:0] data;
    } cmd_t;

    // weight or winning score, with column
    typedef struct packed {
        neuron_pkg::score_t value;
        neuron_pkg::col_t   index;
    } rsp_t;
endpackage

// ==== logic/weight_if.sv ====
`include "core_cfg.svh"

interface weight_if;
    logic [`CORE_DATA_BITS-1:0] data;       // deltas or set value
    neuron_pkg::wm_inst_t       inst;
    logic                       exec;       // one pulse per write
    neuron_pkg::weight_t        read_reg;   // addressed weight

    modport control (
        output data,
        output inst,
        output exec,
        input  read_reg
    );

    modport store (
        input  data,
        input  inst,
        input  exec,
        output read_reg
    );
endinterface

// ==== logic/weight_manager.sv ====
`include "core_cfg.svh"

module weight_manager (
    input  logic                clk,
    input  logic                rstb,
    weight_if.store             wm,
    output neuron_pkg::weight_t weights [`CORE_COLUMNS-1:0][`CORE_ROWS-1:0]
);
    typedef enum logic {
        READY,
        HALT
    } wm_state_e;

    wm_state_e           state;
    logic                is_increment;
    neuron_pkg::col_t    col_addr;
    neuron_pkg::row_t    row_addr;
    neuron_pkg::weight_t delta        [`CORE_COLUMNS-1:0];
    neuron_pkg::weight_t next_weights [`CORE_COLUMNS-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_increment = wm.inst.is_increment;
    assign col_addr     = wm.inst.col;
    assign row_addr     = wm.inst.row;

    assign wm.read_reg  = weights[col_addr][row_addr];

    // new value for each column of the addressed row
    always_comb begin
        for (int c = 0; c < `CORE_COLUMNS; c++) begin
            delta[c] = neuron_pkg::weight_t'($signed(wm.data[2*c +: 2]));  // sign extend
            if (is_increment) begin
                next_weights[c] = weights[c][row_addr] + delta[c];    // wraps
            end else if (neuron_pkg::col_t'(c) == col_addr) begin
                next_weights[c] = wm.data[`CORE_WEIGHT_BITS-1:0];
            end else begin
                next_weights[c] = weights[c][row_addr];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one write per exec pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state <= READY;
            for (int c = 0; c < `CORE_COLUMNS; c++) begin
                for (int r = 0; r < `CORE_ROWS; r++) begin
                    weights[c][r] <= '0;
                end
            end
        end else begin
            case (state)
                READY: begin
                    if (wm.exec) begin
                        for (int c = 0; c < `CORE_COLUMNS; c++) begin
                            weights[c][row_addr] <= next_weights[c];
                        end
                        state <= HALT;
                    end
                end
                HALT: begin
                    if (!wm.exec) begin
                        state <= READY;     // wait for exec to drop
                    end
                end
                default: state <= READY;
            endcase
        end
    end

endmodule

// ==== logic/reg_slice.sv ====
module reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rstb,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // empty, or the entry leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== logic/core_control.sv ====
`include "core_cfg.svh"

module core_control (
    input  logic                   clk,
    input  logic                   rstb,

    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  cmd_pkg::cmd_t          cmd,

    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output cmd_pkg::rsp_t          rsp,

    weight_if.control              wm,

    output logic                   eval_start,
    output logic [`CORE_ROWS-1:0]  eval_inputs,
    input  logic                   eval_done,
    input  neuron_pkg::score_t     eval_score,
    input  neuron_pkg::col_t       eval_col
);
    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        SETTLE,
        EVAL_WAIT,
        RESPOND
    } ctl_state_e;

    ctl_state_e                 state;
    logic                       take;
    cmd_pkg::opcode_e           op_q;
    neuron_pkg::wm_inst_t       inst_q;
    logic [`CORE_DATA_BITS-1:0] data_q;
    cmd_pkg::rsp_t              rsp_q;

    assign cmd_ready = (state == IDLE);
    assign take      = cmd_valid && cmd_ready;

    assign rsp_valid = (state == RESPOND);
    assign rsp       = rsp_q;

    assign wm.inst   = inst_q;
    assign wm.data   = data_q;
    assign wm.exec   = (state == EXEC) && (op_q != cmd_pkg::READ);  // read only settles

    assign eval_inputs = data_q[`CORE_ROWS-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state      <= IDLE;
            eval_start <= 1'b0;
        end else begin
            eval_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (take) begin
                        if (cmd.op == cmd_pkg::EVAL) begin
                            state      <= EVAL_WAIT;
                            eval_start <= 1'b1;
                        end else begin
                            state <= EXEC;
                        end
                    end
                end
                EXEC:      state <= SETTLE;     // store goes back to ready here
                SETTLE:    state <= RESPOND;
                EVAL_WAIT: begin
                    if (eval_done) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default:   state <= IDLE;
            endcase
        end
    end

    // command latch and response capture
    always_ff @(posedge clk) begin
        if (take) begin
            op_q                <= cmd.op;
            inst_q.is_increment <= (cmd.op == cmd_pkg::INC);
            inst_q.col          <= cmd.col;
            inst_q.row          <= cmd.row;
            data_q              <= cmd.data;
        end
        if (state == SETTLE) begin
            rsp_q.value <= neuron_pkg::score_t'(wm.read_reg);   // post-write weight
            rsp_q.index <= inst_q.col;
        end else if (state == EVAL_WAIT && eval_done) begin
            rsp_q.value <= eval_score;
            rsp_q.index <= eval_col;
        end
    end

endmodule

// ==== logic/evidence_accumulator.sv ====
`include "core_cfg.svh"

module evidence_accumulator (
    input  logic                  clk,
    input  logic                  rstb,
    input  neuron_pkg::weight_t   weights [`CORE_COLUMNS-1:0][`CORE_ROWS-1:0],
    input  logic                  start,
    input  logic [`CORE_ROWS-1:0] inputs,
    output logic                  done,
    output neuron_pkg::score_t    best_score,
    output neuron_pkg::col_t      best_col
);
    logic                  busy;
    neuron_pkg::row_t      row;
    logic [`CORE_ROWS-1:0] in_bits;
    neuron_pkg::score_t    score [`CORE_COLUMNS-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // row walk, one row per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            busy <= 1'b0;
            row  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                row  <= '0;
            end else if (busy) begin
                row <= row + 1'b1;
                if (row == neuron_pkg::row_t'(`CORE_ROWS-1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;   // scores final from here
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            in_bits <= inputs;
            for (int c = 0; c < `CORE_COLUMNS; c++) begin
                score[c] <= '0;
            end
        end else if (busy && in_bits[row]) begin
            for (int c = 0; c < `CORE_COLUMNS; c++) begin
                score[c] <= score[c] + neuron_pkg::score_t'(weights[c][row]);
            end
        end
    end

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best_score = score[0];
        best_col   = '0;
        for (int c = 1; c < `CORE_COLUMNS; c++) begin
            if (score[c] > best_score) begin
                best_score = score[c];
                best_col   = neuron_pkg::col_t'(c);
            end
        end
    end

endmodule

// ==== logic/learning_core.sv ====
`include "core_cfg.svh"

module learning_core (
    input  logic                       clk,
    input  logic                       rstb,

    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  cmd_pkg::opcode_e           cmd_op,
    input  neuron_pkg::col_t           cmd_col,
    input  neuron_pkg::row_t           cmd_row,
    input  logic [`CORE_DATA_BITS-1:0] cmd_data,

    output logic                       rsp_valid,
    input  logic                       rsp_ready,
    output neuron_pkg::score_t         rsp_value,
    output neuron_pkg::col_t           rsp_index
);
    cmd_pkg::cmd_t         cmd_in;
    cmd_pkg::cmd_t         ctl_cmd;
    logic                  ctl_cmd_valid;
    logic                  ctl_cmd_ready;

    cmd_pkg::rsp_t         ctl_rsp;
    cmd_pkg::rsp_t         rsp_out;
    logic                  ctl_rsp_valid;
    logic                  ctl_rsp_ready;

    neuron_pkg::weight_t   weights [`CORE_COLUMNS-1:0][`CORE_ROWS-1:0];
    logic                  eval_start;
    logic [`CORE_ROWS-1:0] eval_inputs;
    logic                  eval_done;
    neuron_pkg::score_t    eval_score;
    neuron_pkg::col_t      eval_col;

    weight_if wm_bus ();

    assign cmd_in    = '{op: cmd_op, col: cmd_col, row: cmd_row, data: cmd_data};
    assign rsp_value = rsp_out.value;
    assign rsp_index = rsp_out.index;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    reg_slice #(.payload_t(cmd_pkg::cmd_t)) cmd_stage (
        .clk(clk), .rstb(rstb),
        .in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd_in),
        .out_valid(ctl_cmd_valid), .out_ready(ctl_cmd_ready), .out_data(ctl_cmd)
    );

    core_control u_control (
        .clk(clk), .rstb(rstb),
        .cmd_valid(ctl_cmd_valid), .cmd_ready(ctl_cmd_ready), .cmd(ctl_cmd),
        .rsp_valid(ctl_rsp_valid), .rsp_ready(ctl_rsp_ready), .rsp(ctl_rsp),
        .wm(wm_bus),
        .eval_start(eval_start), .eval_inputs(eval_inputs), .eval_done(eval_done),
        .eval_score(eval_score), .eval_col(eval_col)
    );

    weight_manager u_weights (.clk(clk), .rstb(rstb), .wm(wm_bus), .weights(weights));

    evidence_accumulator u_eval (
        .clk(clk), .rstb(rstb), .weights(weights),
        .start(eval_start), .inputs(eval_inputs), .done(eval_done),
        .best_score(eval_score), .best_col(eval_col)
    );

    // response path
    reg_slice #(.payload_t(cmd_pkg::rsp_t)) rsp_stage (
        .clk(clk), .rstb(rstb),
        .in_valid(ctl_rsp_valid), .in_ready(ctl_rsp_ready), .in_data(ctl_rsp),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp_out)
    );

endmodule

// ==== verification/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic rstb
);
    initial begin
        clk  = 1'b0;
        rstb = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstb = 1'b1;    // released away from the active edge
    end

    always #50 clk = ~clk;
endmodule

// ==== verification/learning_core_properties.sv ====
module learning_core_properties (
    input logic               clk,
    input logic               rstb,
    input logic               ctl_cmd_valid,
    input logic               ctl_cmd_ready,
    input cmd_pkg::cmd_t      ctl_cmd,
    input logic               rsp_valid,
    input logic               rsp_ready,
    input neuron_pkg::score_t rsp_value,
    input neuron_pkg::col_t   rsp_index,
    input logic               wm_exec
);
    int failures = 0;   // assertion failures so far

    // command slice output while the controller is busy
    cmd_hold: assert property (@(posedge clk) disable iff (!rstb)
        ctl_cmd_valid && !ctl_cmd_ready |=> ctl_cmd_valid && $stable(ctl_cmd))
        else begin
            failures++;
            $error("command dropped or changed while stalled");
        end

    rsp_hold: assert property (@(posedge clk) disable iff (!rstb)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable({rsp_value, rsp_index}))
        else begin
            failures++;
            $error("response dropped or changed while stalled");
        end

    // store needs exec low between writes
    exec_pulse: assert property (@(posedge clk) disable iff (!rstb) wm_exec |=> !wm_exec)
        else begin
            failures++;
            $error("exec high on two cycles in a row");
        end

    rsp_idle_after_reset: assert property (@(posedge clk) $rose(rstb) |-> !rsp_valid)
        else begin
            failures++;
            $error("response valid right after reset");
        end
endmodule

bind learning_core learning_core_properties u_properties (.*, .wm_exec(wm_bus.exec));

// ==== verification/tb_learning_core.sv ====
`include "core_cfg.svh"

module tb_learning_core;
    localparam int COLS  = `CORE_COLUMNS;
    localparam int ROWS  = `CORE_ROWS;
    localparam int WBITS = `CORE_WEIGHT_BITS;
    localparam int DBITS = `CORE_DATA_BITS;
    localparam int SBITS = WBITS + $clog2(ROWS);
    localparam int N_B2B = 24;
    // command count of each test in run order
    localparam int N_CMDS = COLS*ROWS + 8*(1+COLS) + (21+COLS*ROWS) + (COLS*ROWS+20) + N_B2B;
    localparam int CYCLE_LIMIT = 2 * N_CMDS * (ROWS + 6);

    logic               clk;
    logic               rstb;
    logic               cmd_valid;
    logic               cmd_ready;
    cmd_pkg::opcode_e   cmd_op;
    neuron_pkg::col_t   cmd_col;
    neuron_pkg::row_t   cmd_row;
    logic [DBITS-1:0]   cmd_data;
    logic               rsp_valid;
    logic               rsp_ready;
    neuron_pkg::score_t rsp_value;
    neuron_pkg::col_t   rsp_index;

    logic signed [WBITS-1:0] model [COLS][ROWS];
    logic [SBITS-1:0]        exp_value_q [$];
    logic [31:0]             exp_index_q [$];
    integer                  seed   = 32'hf6ac5f60;
    int                      errors = 0;
    int                      checks = 0;
    int                      cycles = 0;

    clk_gen u_clk (.clk(clk), .rstb(rstb));

    learning_core DUT (.*);

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host side tasks start and end on a falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_cmd(input cmd_pkg::opcode_e op, input int col, input int row,
                            input logic [DBITS-1:0] data);
        cmd_op    = op;
        cmd_col   = neuron_pkg::col_t'(col);
        cmd_row   = neuron_pkg::row_t'(row);
        cmd_data  = data;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);     // taken on the edge just passed
        cmd_valid = 1'b0;
    endtask

    // model update and expected response before the handshake
    task automatic issue(input cmd_pkg::opcode_e op, input int col, input int row,
                         input logic [DBITS-1:0] data);
        logic signed [WBITS-1:0] delta;
        int sum;
        int best;
        int best_col;
        if (op == cmd_pkg::SET) begin
            model[col][row] = data[WBITS-1:0];
        end else if (op == cmd_pkg::INC) begin
            for (int c = 0; c < COLS; c++) begin
                delta = {{(WBITS-2){data[2*c+1]}}, data[2*c +: 2]};
                model[c][row] = model[c][row] + delta;     // wraps like the store
            end
        end
        if (op == cmd_pkg::EVAL) begin
            best     = 0;
            best_col = 0;
            for (int c = 0; c < COLS; c++) begin
                sum = 0;
                for (int r = 0; r < ROWS; r++) begin
                    if (data[r]) sum += int'(model[c][r]);
                end
                if (c == 0 || sum > best) begin
                    best     = sum;
                    best_col = c;
                end
            end
            exp_value_q.push_back(SBITS'(best));
            exp_index_q.push_back(best_col);
        end else begin
            exp_value_q.push_back(SBITS'(model[col][row]));
            exp_index_q.push_back(col);
        end
        send_cmd(op, col, row, data);
    endtask

    task automatic get_rsp();
        logic [SBITS-1:0] got_value;
        logic [31:0]      got_index;
        bit               taken;
        taken = 1'b0;
        while (!taken) begin
            rsp_ready = ($random(seed) & 3) != 0;  // stall about one cycle in four
            if (rsp_valid && rsp_ready) begin
                got_value = rsp_value;
                got_index = rsp_index;
                taken     = 1'b1;
            end
            @(negedge clk);
        end
        rsp_ready = 1'b0;
        check("rsp_value", got_value, exp_value_q.pop_front());
        check("rsp_index", got_index, exp_index_q.pop_front());
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_reads();
        int e0;
        e0 = errors;
        for (int c = 0; c < COLS; c++) begin
            for (int r = 0; r < ROWS; r++) begin
                issue(cmd_pkg::READ, c, r, '0);
                get_rsp();
            end
        end
        report_test("reset reads", e0);
    endtask

    task automatic set_and_read_row();
        int e0;
        int row;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            row = rand_below(ROWS);
            issue(cmd_pkg::SET, rand_below(COLS), row, DBITS'($random(seed)));
            get_rsp();
            for (int c = 0; c < COLS; c++) begin   // neighbours unchanged
                issue(cmd_pkg::READ, c, row, '0);
                get_rsp();
            end
        end
        report_test("set", e0);
    endtask

    task automatic inc_rows();
        int e0;
        e0 = errors;
        issue(cmd_pkg::SET, 0, 3, 8'h7f);
        get_rsp();
        issue(cmd_pkg::SET, 1, 3, 8'h80);
        get_rsp();
        issue(cmd_pkg::SET, 2, 3, 8'h7e);
        get_rsp();
        issue(cmd_pkg::SET, 3, 3, 8'h81);
        get_rsp();
        issue(cmd_pkg::INC, 2, 3, 8'h9d);   // deltas +1 -1 +1 -2 with three wraps
        get_rsp();
        for (int i = 0; i < 16; i++) begin
            issue(cmd_pkg::INC, rand_below(COLS), rand_below(ROWS), DBITS'($random(seed)));
            get_rsp();
        end
        for (int c = 0; c < COLS; c++) begin
            for (int r = 0; r < ROWS; r++) begin
                issue(cmd_pkg::READ, c, r, '0);
                get_rsp();
            end
        end
        report_test("inc", e0);
    endtask

    task automatic eval_winners();
        int               e0;
        logic [DBITS-1:0] vec;
        e0 = errors;
        for (int c = 0; c < COLS; c++) begin
            for (int r = 0; r < ROWS; r++) begin
                issue(cmd_pkg::SET, c, r, DBITS'($random(seed)));
                get_rsp();
            end
        end
        for (int i = 0; i < 20; i++) begin
            vec = (i == 0) ? '0 : (i == 1) ? '1 : DBITS'($random(seed));  // all-zero is a full tie
            issue(cmd_pkg::EVAL, 0, 0, vec);
            get_rsp();
        end
        report_test("eval", e0);
    endtask

    task automatic back_to_back();
        int e0;
        int extra;
        e0 = errors;
        fork
            for (int i = 0; i < N_B2B; i++) begin
                issue(cmd_pkg::opcode_e'(rand_below(4)), rand_below(COLS), rand_below(ROWS),
                      DBITS'($random(seed)));
            end
            for (int i = 0; i < N_B2B; i++) begin
                get_rsp();
            end
        join
        extra     = 0;
        rsp_ready = 1'b1;
        repeat (ROWS + 8) begin
            @(negedge clk);
            if (rsp_valid) extra++;
        end
        rsp_ready = 1'b0;
        checks++;
        if (extra != 0) begin
            errors++;
            $display("%0d responses arrived after the last command was answered", extra);
        end
        report_test("back to back", e0);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a command or response never completed", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        cmd_valid = 1'b0;
        cmd_op    = cmd_pkg::SET;
        cmd_col   = '0;
        cmd_row   = '0;
        cmd_data  = '0;
        rsp_ready = 1'b0;
        for (int c = 0; c < COLS; c++) begin
            for (int r = 0; r < ROWS; r++) begin
                model[c][r] = '0;
            end
        end
        @(posedge rstb);
        @(negedge clk);
        reset_reads();
        set_and_read_row();
        inc_rows();
        eval_winners();
        back_to_back();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, DUT.u_properties.failures);
        if (errors == 0 && DUT.u_properties.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

// ==== build.f ====
+incdir+logic
logic/neuron_pkg.sv
logic/cmd_pkg.sv
logic/weight_if.sv
logic/weight_manager.sv
logic/reg_slice.sv
logic/core_control.sv
logic/evidence_accumulator.sv
logic/learning_core.sv
verification/clk_gen.sv
verification/learning_core_properties.sv
verification/tb_learning_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_learning_core
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	@cat $(LOG)
	@! grep -q "Simulation failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
